// ==== hw/mul_pkg.sv ====
// Multiplier shared types
package mul_pkg;

	// Operand and result width
	localparam int XLEN = 32;

	// Width of the extended operands and of the full product
	localparam int DXLEN = 2 * XLEN;

	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [DXLEN-1:0] dword_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Same encoding as RV32M funct3[1:0]
	typedef enum logic [1:0] {
		OP_MUL    = 2'b00,
		OP_MULH   = 2'b01,
		OP_MULHSU = 2'b10,
		OP_MULHU  = 2'b11
	} mul_op_e;

	typedef struct packed {
		mul_op_e   op;
		reg_addr_t rd;
		word_t     pc;
		word_t     a;
		word_t     b;
	} mul_req_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t     pc;
		word_t     result;
	} mul_rsp_t;

	// One pipeline slot
	typedef struct packed {
		logic      valid;
		mul_op_e   op;
		reg_addr_t rd;
		word_t     pc;
		// Multiplicand, already shifted by the bits consumed so far
		dword_t    mcand;
		// Multiplier bits still to be consumed
		dword_t    mplier;
		dword_t    acc;
	} mul_acc_t;

endpackage

// ==== hw/mul_issue.sv ====
// Multiplier request issue
`timescale 1ns/100ps

module mul_issue (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               req_valid_i,
	input  mul_pkg::mul_req_t  req_i,
	input  logic               advance_i,
	input  logic               flush_i,
	output logic               req_ready_o,
	output mul_pkg::mul_acc_t  acc_o
);

	logic              signed_a;
	logic              signed_b;
	mul_pkg::dword_t   a_ext;
	mul_pkg::dword_t   b_ext;
	mul_pkg::mul_acc_t acc_d;
	mul_pkg::mul_acc_t acc_q;

	// No request is taken while the pipeline is being killed
	assign req_ready_o = advance_i & ~flush_i;

	// MULH treats both operands as signed, MULHSU only rs1
	assign signed_a = (req_i.op == mul_pkg::OP_MULH) ||
		(req_i.op == mul_pkg::OP_MULHSU);
	assign signed_b = (req_i.op == mul_pkg::OP_MULH);

	assign a_ext = {{mul_pkg::XLEN{signed_a & req_i.a[mul_pkg::XLEN-1]}}, req_i.a};
	assign b_ext = {{mul_pkg::XLEN{signed_b & req_i.b[mul_pkg::XLEN-1]}}, req_i.b};

	always_comb begin
		acc_d.valid  = req_valid_i;
		acc_d.op     = req_i.op;
		acc_d.rd     = req_i.rd;
		acc_d.pc     = req_i.pc;
		acc_d.mcand  = a_ext;
		acc_d.mplier = b_ext;
		acc_d.acc    = '0;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			acc_q.valid <= 1'b0;
		end else if (flush_i) begin
			acc_q.valid <= 1'b0;
		end else if (advance_i) begin
			acc_q <= acc_d;
		end
	end

	assign acc_o = acc_q;

	// A kill blocks acceptance and leaves the issue slot empty
	a_flush_blocks_issue: assert property (
		@(posedge clk_i) disable iff (reset_i)
		flush_i |-> !req_ready_o ##1 !acc_o.valid
	);

endmodule

// ==== hw/mul_stage.sv ====
// Multiplier partial product stage
`timescale 1ns/100ps

module mul_stage #(
	parameter int NUM_STAGES = 4
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               advance_i,
	input  logic               flush_i,
	input  mul_pkg::mul_acc_t  acc_i,
	output mul_pkg::mul_acc_t  acc_o
);

	// Multiplier bits consumed per stage
	localparam int SLICE_W = mul_pkg::DXLEN / NUM_STAGES;

	mul_pkg::dword_t   partial;
	mul_pkg::mul_acc_t acc_d;
	mul_pkg::mul_acc_t acc_q;

	if ((mul_pkg::DXLEN % NUM_STAGES) != 0) begin : gen_bad_depth
		$error("NUM_STAGES must divide the product width");
	end

	// Shift-and-add over the low slice of the remaining multiplier
	always_comb begin
		partial = acc_i.acc;
		for (int i = 0; i < SLICE_W; i++) begin
			if (acc_i.mplier[i]) begin
				partial = partial + (acc_i.mcand << i);
			end
		end
	end

	// Product is kept modulo 2^64, which is exact for the extended operands
	always_comb begin
		acc_d        = acc_i;
		acc_d.mcand  = acc_i.mcand << SLICE_W;
		acc_d.mplier = acc_i.mplier >> SLICE_W;
		acc_d.acc    = partial;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			acc_q.valid <= 1'b0;
		end else if (flush_i) begin
			acc_q.valid <= 1'b0;
		end else if (advance_i) begin
			acc_q <= acc_d;
		end
	end

	assign acc_o = acc_q;

	// A bubble stays a bubble
	a_no_spurious_valid: assert property (
		@(posedge clk_i) disable iff (reset_i)
		advance_i && !acc_i.valid |=> !acc_o.valid
	);

endmodule

// ==== hw/mul_writeback.sv ====
// Multiplier write-back and pipeline control
`timescale 1ns/100ps

module mul_writeback (
	input  logic               clk_i,
	input  logic               reset_i,
	input  mul_pkg::mul_acc_t  acc_i,
	input  logic               rsp_ready_i,
	input  logic               kill_i,
	output logic               rsp_valid_o,
	output mul_pkg::mul_rsp_t  rsp_o,
	output logic               advance_o,
	output logic               flush_o
);

	logic              run_q;
	logic              rsp_valid_q;
	logic              load;
	mul_pkg::word_t    result;
	mul_pkg::mul_rsp_t rsp_d;
	mul_pkg::mul_rsp_t rsp_q;

	// MUL returns the low word, the MULH family the high word
	assign result = (acc_i.op == mul_pkg::OP_MUL) ?
		acc_i.acc[mul_pkg::XLEN-1:0] :
		acc_i.acc[mul_pkg::DXLEN-1:mul_pkg::XLEN];

	always_comb begin
		rsp_d.rd     = acc_i.rd;
		rsp_d.pc     = acc_i.pc;
		rsp_d.result = result;
	end

	// Whole pipeline moves when the output register can take a new entry
	assign advance_o = run_q & (~rsp_valid_q | rsp_ready_i);
	assign flush_o   = kill_i;

	// A killed slot never reaches the output register
	assign load = advance_o & acc_i.valid & ~kill_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			run_q       <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (load) begin
				rsp_valid_q <= 1'b1;
			end else if (rsp_ready_i) begin
				rsp_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			rsp_q <= rsp_d;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

	// Response holds until the consumer takes it
	a_rsp_stable: assert property (
		@(posedge clk_i) disable iff (reset_i)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o)
	);

endmodule

// ==== hw/mul_pipe_top.sv ====
// Pipelined RV32M multiplier
`timescale 1ns/100ps

module mul_pipe_top #(
	parameter int NUM_STAGES = 4
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               req_valid_i,
	output logic               req_ready_o,
	input  mul_pkg::mul_req_t  req_i,
	output logic               rsp_valid_o,
	input  logic               rsp_ready_i,
	output mul_pkg::mul_rsp_t  rsp_o,
	input  logic               kill_i
);

	logic              advance;
	logic              flush;

	// Slot 0 is the issue register, slot k+1 the output of stage k
	mul_pkg::mul_acc_t slot [NUM_STAGES+1];

	mul_issue issue_inst (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.advance_i   (advance),
		.flush_i     (flush),
		.req_ready_o (req_ready_o),
		.acc_o       (slot[0])
	);

	for (genvar k = 0; k < NUM_STAGES; k++) begin : gen_stage
		mul_stage #(
			.NUM_STAGES (NUM_STAGES)
		) stage_inst (
			.clk_i     (clk_i),
			.reset_i   (reset_i),
			.advance_i (advance),
			.flush_i   (flush),
			.acc_i     (slot[k]),
			.acc_o     (slot[k+1])
		);
	end

	mul_writeback writeback_inst (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.acc_i       (slot[NUM_STAGES]),
		.rsp_ready_i (rsp_ready_i),
		.kill_i      (kill_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o),
		.advance_o   (advance),
		.flush_o     (flush)
	);

	// A stalled response freezes the request side as well
	a_backpressure_stalls_issue: assert property (
		@(posedge clk_i) disable iff (reset_i)
		rsp_valid_o && !rsp_ready_i |-> !req_ready_o
	);

endmodule

// ==== dv/mul_pipe_tb.sv ====
// Multiplier pipeline testbench
`timescale 1ns/100ps

module mul_pipe_tb;

	localparam int NUM_STAGES = 4;
	localparam int NUM_SINGLE = 8;
	localparam int NUM_RANDOM = 300;
	localparam int NUM_AFTER_KILL = 100;
	localparam int NUM_REQUESTS = NUM_SINGLE + NUM_RANDOM + NUM_STAGES + 2 + NUM_AFTER_KILL;
	localparam int TIMEOUT_NS = (NUM_REQUESTS + 100) * (NUM_STAGES + 2) * 10;
	// Every slot empties well within this many cycles once the consumer is ready
	localparam int DRAIN_CYCLES = 2 * (NUM_STAGES + 2);

	logic              clk_i = 1'b0;
	logic              reset_i;
	logic              req_valid_i;
	logic              req_ready_o;
	mul_pkg::mul_req_t req_i;
	logic              rsp_valid_o;
	logic              rsp_ready_i;
	mul_pkg::mul_rsp_t rsp_o;
	logic              kill_i;

	integer            seed = 72499;
	logic              lat_mode = 1'b0;

	// Scoreboard state seen by the assertions
	int                exp_count = 0;
	mul_pkg::mul_rsp_t exp_front;
	logic              hold_armed = 1'b0;
	mul_pkg::mul_rsp_t held_rsp;
	logic              lat_armed = 1'b0;
	int                lat_cycles = 0;
	logic              reset_seen = 1'b0;

	mul_pipe_top #(
		.NUM_STAGES (NUM_STAGES)
	) mul_pipe_top_inst (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_i       (req_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_o       (rsp_o),
		.kill_i      (kill_i)
	);

	always #5 clk_i = ~clk_i;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	// Reference model of the four RV32M multiply operations
	function automatic mul_pkg::word_t model_result(input mul_pkg::mul_op_e op,
		input mul_pkg::word_t a, input mul_pkg::word_t b);
		longint sa;
		longint sb;
		longint ua;
		longint ub;
		longint prod;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ua = longint'({32'b0, a});
		ub = longint'({32'b0, b});
		case (op)
			mul_pkg::OP_MULH:   prod = sa * sb;
			mul_pkg::OP_MULHSU: prod = sa * ub;
			default:            prod = ua * ub;
		endcase
		if (op == mul_pkg::OP_MUL) begin
			return prod[31:0];
		end else begin
			return prod[63:32];
		end
	endfunction

	function automatic mul_pkg::mul_rsp_t expected_response(input mul_pkg::mul_req_t req);
		mul_pkg::mul_rsp_t rsp;
		rsp.rd = req.rd;
		rsp.pc = req.pc;
		rsp.result = model_result(req.op, req.a, req.b);
		return rsp;
	endfunction

	// Corner values show up often next to plain random ones
	function automatic mul_pkg::word_t random_operand();
		int pick;
		pick = {$random(seed)} % 8;
		case (pick)
			0: return 32'h0000_0000;
			1: return 32'h0000_0001;
			2: return 32'hffff_ffff;
			3: return 32'h8000_0000;
			default: return $random(seed);
		endcase
	endfunction

	function automatic mul_pkg::mul_req_t random_request();
		mul_pkg::mul_req_t req;
		logic [31:0] rnd;
		rnd = $random(seed);
		req.op = mul_pkg::mul_op_e'(rnd[1:0]);
		req.rd = rnd[6:2];
		req.pc = {rnd[31:7], 7'b0} | {$random(seed)} & 32'h0000_007c;
		req.a = random_operand();
		req.b = random_operand();
		return req;
	endfunction

	always @(posedge clk_i) begin : scoreboard
		mul_pkg::mul_rsp_t expected[$];
		mul_pkg::mul_rsp_t kept;
		logic              keep;
		if (reset_i) begin
			reset_seen <= 1'b1;
		end
		if (rsp_valid_o && rsp_ready_i && expected.size() > 0) begin
			void'(expected.pop_front());
		end
		// Kill drops everything behind a response that is still held
		if (kill_i) begin
			keep = rsp_valid_o && !rsp_ready_i && expected.size() > 0;
			if (keep) begin
				kept = expected[0];
			end
			expected.delete();
			if (keep) begin
				expected.push_back(kept);
			end
		end
		if (req_valid_i && req_ready_o) begin
			expected.push_back(expected_response(req_i));
		end
		exp_count <= expected.size();
		if (expected.size() > 0) begin
			exp_front <= expected[0];
		end
		hold_armed <= rsp_valid_o && !rsp_ready_i;
		held_rsp <= rsp_o;
		// Edges counted from the accepting edge of a lone request
		if (lat_armed && rsp_valid_o) begin
			lat_armed <= 1'b0;
		end else if (lat_armed) begin
			lat_cycles <= lat_cycles + 1;
		end
		if (lat_mode && req_valid_i && req_ready_o) begin
			lat_armed <= 1'b1;
			lat_cycles <= 1;
		end
	end

	a_reset_quiet: assert property (@(posedge clk_i)
		reset_i && reset_seen |-> !rsp_valid_o && !req_ready_o)
		else report_failure("Response valid or request ready was high during reset");

	a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
		rsp_valid_o |-> exp_count != 0)
		else report_failure("A response appeared with no request outstanding");

	a_rsp_rd: assert property (@(posedge clk_i) disable iff (reset_i)
		rsp_valid_o && exp_count != 0 |-> rsp_o.rd == exp_front.rd)
		else report_failure($sformatf("Mismatch at %0t: rsp_o.rd expected %0d actual %0d",
			$time, $sampled(exp_front.rd), $sampled(rsp_o.rd)));

	a_rsp_pc: assert property (@(posedge clk_i) disable iff (reset_i)
		rsp_valid_o && exp_count != 0 |-> rsp_o.pc == exp_front.pc)
		else report_failure($sformatf("Mismatch at %0t: rsp_o.pc expected %h actual %h",
			$time, $sampled(exp_front.pc), $sampled(rsp_o.pc)));

	a_rsp_result: assert property (@(posedge clk_i) disable iff (reset_i)
		rsp_valid_o && exp_count != 0 |-> rsp_o.result == exp_front.result)
		else report_failure($sformatf("Mismatch at %0t: rsp_o.result expected %h actual %h",
			$time, $sampled(exp_front.result), $sampled(rsp_o.result)));

	a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
		lat_armed && rsp_valid_o |-> lat_cycles == NUM_STAGES + 2)
		else report_failure($sformatf("Mismatch at %0t: latency expected %0d actual %0d",
			$time, NUM_STAGES + 2, $sampled(lat_cycles)));

	a_hold_valid: assert property (@(posedge clk_i) disable iff (reset_i)
		hold_armed |-> rsp_valid_o)
		else report_failure("Response valid dropped before the response was taken");

	a_hold_data: assert property (@(posedge clk_i) disable iff (reset_i)
		hold_armed |-> rsp_o == held_rsp)
		else report_failure($sformatf("Mismatch at %0t: rsp_o expected %h actual %h",
			$time, $sampled(held_rsp), $sampled(rsp_o)));

	a_stall_ready: assert property (@(posedge clk_i) disable iff (reset_i)
		rsp_valid_o && !rsp_ready_i |-> !req_ready_o)
		else report_failure("Request ready was high while the response was stalled");

	a_kill_ready: assert property (@(posedge clk_i) disable iff (reset_i)
		kill_i |-> !req_ready_o)
		else report_failure("Request ready was high during a kill");

	// One request in flight, consumer always ready
	task automatic issue_single(input mul_pkg::mul_req_t req);
		req_i = req;
		req_valid_i = 1'b1;
		do @(posedge clk_i); while (!req_ready_o);
		#1;
		req_valid_i = 1'b0;
		do @(posedge clk_i); while (!rsp_valid_o);
		#1;
	endtask

	task automatic drive_traffic(input int num_req, input int ready_pct, input int kill_pct);
		int   accepted;
		logic took;
		accepted = 0;
		while (accepted < num_req) begin
			@(posedge clk_i);
			took = req_valid_i && req_ready_o;
			if (took) begin
				accepted++;
			end
			#1;
			if (took || !req_valid_i) begin
				req_valid_i = (accepted < num_req) && (({$random(seed)} % 4) != 0);
				req_i = random_request();
			end
			rsp_ready_i = ({$random(seed)} % 100) < ready_pct;
			kill_i = ({$random(seed)} % 100) < kill_pct;
		end
		req_valid_i = 1'b0;
		kill_i = 1'b0;
	endtask

	task automatic drain();
		int cycles;
		req_valid_i = 1'b0;
		kill_i = 1'b0;
		rsp_ready_i = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk_i);
			#1;
			cycles++;
		end while ((exp_count != 0 || rsp_valid_o) && cycles < DRAIN_CYCLES);
		if (exp_count != 0) begin
			report_failure("Some expected responses never arrived");
		end
	endtask

	// Kill with a full pipeline and a response held in the output register
	task automatic kill_full_pipeline();
		int i;
		rsp_ready_i = 1'b0;
		for (i = 0; i < NUM_STAGES + 2; i++) begin
			req_i = random_request();
			req_valid_i = 1'b1;
			do @(posedge clk_i); while (!req_ready_o);
			#1;
		end
		req_i = random_request();
		req_valid_i = 1'b1;
		kill_i = 1'b1;
		@(posedge clk_i);
		#1;
		kill_i = 1'b0;
		req_valid_i = 1'b0;
		rsp_ready_i = 1'b1;
	endtask

	initial begin : stimulus
		mul_pkg::mul_req_t req;
		int                i;
		reset_i = 1'b1;
		req_valid_i = 1'b0;
		req_i = '0;
		rsp_ready_i = 1'b0;
		kill_i = 1'b0;
		repeat (8) @(posedge clk_i);
		#1;
		reset_i = 1'b0;
		rsp_ready_i = 1'b1;

		lat_mode = 1'b1;
		for (i = 0; i < NUM_SINGLE; i++) begin
			req = random_request();
			req.op = mul_pkg::mul_op_e'(i[1:0]);
			req.a = (i < 4) ? 32'h8000_0000 : 32'hffff_ffff;
			req.b = (i < 4) ? 32'hffff_ffff : 32'h8000_0000;
			issue_single(req);
		end
		lat_mode = 1'b0;

		drive_traffic(NUM_RANDOM, 75, 0);
		drain();
		kill_full_pipeline();
		drive_traffic(NUM_AFTER_KILL, 60, 3);
		drain();

		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		report_failure("Timeout: the test did not finish in the expected time");
	end

endmodule

// ==== mul_pipe.f ====
hw/mul_pkg.sv
hw/mul_issue.sv
hw/mul_stage.sv
hw/mul_writeback.sv
hw/mul_pipe_top.sv
dv/mul_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: mul_pipe

sources:
  - files:
      - hw/mul_pkg.sv
      - hw/mul_issue.sv
      - hw/mul_stage.sv
      - hw/mul_writeback.sv
      - hw/mul_pipe_top.sv
  - target: test
    files:
      - dv/mul_pipe_tb.sv
